// ==== clk_gen_cfg.svh ====
// ----------------------------------------
// clock generator configuration
// widths, reset divider, settling time and id version
// ----------------------------------------

`ifndef CLK_GEN_CFG_SVH
`define CLK_GEN_CFG_SVH

// configuration bus address and data widths
`define CLK_CFG_ADDR_W 5
`define CLK_CFG_DATA_W 32

// the divider value is stored in this many bits
`define CLK_DIV_W 8
// every domain comes out of reset dividing by this value
`define CLK_DIV_RESET 2

// ref_clk_i cycles from a reload until the domain reports lock
`define CLK_LOCK_CYCLES 16

// lower half of the identification register
`define CLK_ID_VERSION 16'h0001

`endif

// ==== clk_cfg_pkg.sv ====
// ----------------------------------------
// configuration bus types
// address and data of the req/ack port and the register map
// ----------------------------------------

`include "clk_gen_cfg.svh"

package clk_cfg_pkg;

  // register address as seen on x_cfg_add_i
  typedef logic [`CLK_CFG_ADDR_W-1:0] cfg_addr_t;

  // write data and read data share one width
  typedef logic [`CLK_CFG_DATA_W-1:0] cfg_data_t;

  // ----------------------------------------
  // register map of one domain
  // ----------------------------------------
  // the divider value sits in the low bits of REG_DIV
  // the enable sits in bit 0 of REG_EN
  // REG_STATUS and REG_ID are read only
  // anything else reads as zero
  typedef enum cfg_addr_t {
    REG_DIV    = 5'd0,
    REG_EN     = 5'd1,
    REG_STATUS = 5'd2,
    REG_ID     = 5'd3
  } cfg_reg_e;

endpackage : clk_cfg_pkg

// ==== clk_div_pkg.sv ====
// ----------------------------------------
// clock divider types
// divider value, settle counter and lock FSM states
// ----------------------------------------

`include "clk_gen_cfg.svh"

package clk_div_pkg;

  // number of ref_clk_i cycles per half period of the output clock
  typedef logic [`CLK_DIV_W-1:0] div_value_t;

  // the settle counter must hold CLK_LOCK_CYCLES itself
  typedef logic [$clog2(`CLK_LOCK_CYCLES + 1)-1:0] settle_cnt_t;

  // lock FSM of one domain
  // ST_OFF while the domain is disabled
  // ST_SETTLE while the settle counter runs down
  // ST_LOCKED once the output clock is considered stable
  typedef enum logic [1:0] {
    ST_OFF,
    ST_SETTLE,
    ST_LOCKED
  } lock_state_e;

endpackage : clk_div_pkg

// ==== clk_ctrl_if.sv ====
// ----------------------------------------
// control link between a register block and its divider
// ----------------------------------------

`timescale 1ns/1ps

interface clk_ctrl_if;

  import clk_div_pkg::*;

  // programmed half period and enable
  div_value_t div_value;
  logic       enable;
  // one-cycle strobe that restarts the divider and the settle time
  logic       reload;
  // lock flag reported back by the divider
  logic       locked;

  // the register block owns the setup and only reads lock
  modport regs (output div_value, output enable, output reload, input locked);

  // the divider follows the setup and drives lock
  modport div (input div_value, input enable, input reload, output locked);

endinterface : clk_ctrl_if

// ==== clk_cfg_regs.sv ====
// ----------------------------------------
// register block of one clock domain
// answers the req/ack configuration port and holds the
// divider and enable settings of the domain
// ----------------------------------------

`timescale 1ns/1ps
`include "clk_gen_cfg.svh"

module clk_cfg_regs #(
  parameter logic [15:0] DOMAIN_ID = 16'd1
) (
  input  logic                  ref_clk_i,
  input  logic                  rst_i,
  input  logic                  cfg_req_i,
  input  logic                  cfg_wrn_i,
  input  clk_cfg_pkg::cfg_addr_t cfg_add_i,
  input  clk_cfg_pkg::cfg_data_t cfg_data_i,
  output logic                  cfg_ack_o,
  output clk_cfg_pkg::cfg_data_t cfg_r_data_o,
  clk_ctrl_if.regs              ctrl
);

  import clk_cfg_pkg::*;
  import clk_div_pkg::*;

  logic       ack_q;
  logic       reload_q;
  div_value_t div_q;
  logic       en_q;
  cfg_data_t  r_data_q;
  cfg_data_t  r_data_d;
  logic       access;
  logic       wr_setup;

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  // an access is taken in the cycle req is seen and ack was not given
  // so a req held past its ack starts the next access one cycle later
  assign access = cfg_req_i & ~ack_q;

  // only writes to the divider or the enable touch the clock setup
  assign wr_setup = access & ~cfg_wrn_i &
                    ((cfg_add_i == REG_DIV) || (cfg_add_i == REG_EN));

  // read data from the register map
  // lock is taken straight from the divider
  always_comb begin
    case (cfg_add_i)
      REG_DIV:    r_data_d = cfg_data_t'(div_q);
      REG_EN:     r_data_d = cfg_data_t'(en_q);
      REG_STATUS: r_data_d = cfg_data_t'(ctrl.locked);
      REG_ID:     r_data_d = {DOMAIN_ID, `CLK_ID_VERSION};
      default:    r_data_d = '0;
    endcase
  end

  // ack and reload are both one-cycle pulses in the same cycle
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      reload_q <= 1'b0;
    end else begin
      ack_q    <= access;
      reload_q <= wr_setup;
    end
  end

  // ----------------------------------------
  // settings
  // ----------------------------------------
  // writes land at the start of the ack cycle together with reload
  // read-only and unmapped addresses just get their ack
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      div_q <= div_value_t'(`CLK_DIV_RESET);
      en_q  <= 1'b1;
    end else if (access && !cfg_wrn_i) begin
      if (cfg_add_i == REG_DIV) begin
        div_q <= cfg_data_i[`CLK_DIV_W-1:0];
      end
      if (cfg_add_i == REG_EN) begin
        en_q <= cfg_data_i[0];
      end
    end
  end

  // read data is captured with the access and held through the ack cycle
  always_ff @(posedge ref_clk_i) begin
    if (access) begin
      r_data_q <= r_data_d;
    end
  end

  assign cfg_ack_o    = ack_q;
  assign cfg_r_data_o = r_data_q;

  assign ctrl.div_value = div_q;
  assign ctrl.enable    = en_q;
  assign ctrl.reload    = reload_q;

endmodule : clk_cfg_regs

// ==== clk_div.sv ====
// ----------------------------------------
// programmable clock divider of one domain
// toggles a registered clock every div_value reference cycles
// and reports lock after a fixed settling time
// ----------------------------------------

`timescale 1ns/1ps
`include "clk_gen_cfg.svh"

module clk_div (
  input  logic    ref_clk_i,
  input  logic    rst_i,
  input  logic    test_mode_i,
  output logic    clk_o,
  clk_ctrl_if.div ctrl
);

  import clk_div_pkg::*;

  // the counter is loaded one cycle later after a reload than after reset
  // so both reach lock CLK_LOCK_CYCLES cycles after the event
  localparam settle_cnt_t SETTLE_RESET  = settle_cnt_t'(`CLK_LOCK_CYCLES - 1);
  localparam settle_cnt_t SETTLE_RELOAD = settle_cnt_t'(`CLK_LOCK_CYCLES - 2);

  div_value_t  div_eff;
  div_value_t  tgl_cnt_q;
  logic        clk_q;
  lock_state_e state_q;
  settle_cnt_t settle_q;

  // a programmed zero divides like a one
  assign div_eff = (ctrl.div_value == '0) ? div_value_t'(1) : ctrl.div_value;

  // ----------------------------------------
  // toggle counter
  // ----------------------------------------
  // the output toggles when the counter has seen div_eff cycles
  // which gives a period of twice div_eff at 50 percent duty
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      tgl_cnt_q <= '0;
      clk_q     <= 1'b0;
    end else if (ctrl.reload || !ctrl.enable) begin
      // restart from a low phase, and stay there while disabled
      tgl_cnt_q <= '0;
      clk_q     <= 1'b0;
    end else if (tgl_cnt_q == div_eff - 1'b1) begin
      tgl_cnt_q <= '0;
      clk_q     <= ~clk_q;
    end else begin
      tgl_cnt_q <= tgl_cnt_q + 1'b1;
    end
  end

  // ----------------------------------------
  // lock FSM
  // ----------------------------------------
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      state_q  <= ST_SETTLE;
      settle_q <= SETTLE_RESET;
    end else if (!ctrl.enable) begin
      // a disabled domain never reports lock
      state_q  <= ST_OFF;
      settle_q <= '0;
    end else if (ctrl.reload) begin
      state_q  <= ST_SETTLE;
      settle_q <= SETTLE_RELOAD;
    end else begin
      case (state_q)
        ST_OFF: begin
          // enable only comes back through a write, which reloads
          // this arm just keeps the FSM from getting stuck
          state_q  <= ST_SETTLE;
          settle_q <= SETTLE_RELOAD;
        end
        ST_SETTLE: begin
          if (settle_q == '0) begin
            state_q <= ST_LOCKED;
          end else begin
            settle_q <= settle_q - 1'b1;
          end
        end
        ST_LOCKED: begin
          state_q <= ST_LOCKED;
        end
        default: begin
          state_q <= ST_OFF;
        end
      endcase
    end
  end

  // lock is a plain decode of the registered state
  assign ctrl.locked = (state_q == ST_LOCKED);

  // test mode hands the reference clock straight through
  // lock keeps following the FSM
  assign clk_o = test_mode_i ? ref_clk_i : clk_q;

endmodule : clk_div

// ==== clk_gen.sv ====
// ----------------------------------------
// clock generation subsystem
// derives the soc, per and cluster clocks from ref_clk_i,
// each with its own configuration port
// ----------------------------------------

`timescale 1ns/1ps

module clk_gen (
  input  logic                   ref_clk_i,
  input  logic                   rst_i,
  input  logic                   test_mode_i,
  output logic                   soc_clk_o,
  output logic                   per_clk_o,
  output logic                   cluster_clk_o,
  // soc domain configuration
  input  logic                   soc_cfg_req_i,
  input  logic                   soc_cfg_wrn_i,
  input  clk_cfg_pkg::cfg_addr_t soc_cfg_add_i,
  input  clk_cfg_pkg::cfg_data_t soc_cfg_data_i,
  output logic                   soc_cfg_ack_o,
  output clk_cfg_pkg::cfg_data_t soc_cfg_r_data_o,
  output logic                   soc_cfg_lock_o,
  // peripheral domain configuration
  input  logic                   per_cfg_req_i,
  input  logic                   per_cfg_wrn_i,
  input  clk_cfg_pkg::cfg_addr_t per_cfg_add_i,
  input  clk_cfg_pkg::cfg_data_t per_cfg_data_i,
  output logic                   per_cfg_ack_o,
  output clk_cfg_pkg::cfg_data_t per_cfg_r_data_o,
  output logic                   per_cfg_lock_o,
  // cluster domain configuration
  input  logic                   cluster_cfg_req_i,
  input  logic                   cluster_cfg_wrn_i,
  input  clk_cfg_pkg::cfg_addr_t cluster_cfg_add_i,
  input  clk_cfg_pkg::cfg_data_t cluster_cfg_data_i,
  output logic                   cluster_cfg_ack_o,
  output clk_cfg_pkg::cfg_data_t cluster_cfg_r_data_o,
  output logic                   cluster_cfg_lock_o
);

  // one control link per domain
  clk_ctrl_if soc_ctrl ();
  clk_ctrl_if per_ctrl ();
  clk_ctrl_if cluster_ctrl ();

  // ----------------------------------------
  // soc domain
  // ----------------------------------------
  clk_cfg_regs #(.DOMAIN_ID(16'd1)) i_soc_regs (
    .ref_clk_i, .rst_i,
    .cfg_req_i(soc_cfg_req_i), .cfg_wrn_i(soc_cfg_wrn_i),
    .cfg_add_i(soc_cfg_add_i), .cfg_data_i(soc_cfg_data_i),
    .cfg_ack_o(soc_cfg_ack_o), .cfg_r_data_o(soc_cfg_r_data_o),
    .ctrl(soc_ctrl.regs)
  );

  clk_div i_soc_div (
    .ref_clk_i, .rst_i, .test_mode_i,
    .clk_o(soc_clk_o),
    .ctrl(soc_ctrl.div)
  );

  // ----------------------------------------
  // peripheral domain
  // ----------------------------------------
  clk_cfg_regs #(.DOMAIN_ID(16'd2)) i_per_regs (
    .ref_clk_i, .rst_i,
    .cfg_req_i(per_cfg_req_i), .cfg_wrn_i(per_cfg_wrn_i),
    .cfg_add_i(per_cfg_add_i), .cfg_data_i(per_cfg_data_i),
    .cfg_ack_o(per_cfg_ack_o), .cfg_r_data_o(per_cfg_r_data_o),
    .ctrl(per_ctrl.regs)
  );

  clk_div i_per_div (
    .ref_clk_i, .rst_i, .test_mode_i,
    .clk_o(per_clk_o),
    .ctrl(per_ctrl.div)
  );

  // ----------------------------------------
  // cluster domain
  // ----------------------------------------
  clk_cfg_regs #(.DOMAIN_ID(16'd3)) i_cluster_regs (
    .ref_clk_i, .rst_i,
    .cfg_req_i(cluster_cfg_req_i), .cfg_wrn_i(cluster_cfg_wrn_i),
    .cfg_add_i(cluster_cfg_add_i), .cfg_data_i(cluster_cfg_data_i),
    .cfg_ack_o(cluster_cfg_ack_o), .cfg_r_data_o(cluster_cfg_r_data_o),
    .ctrl(cluster_ctrl.regs)
  );

  clk_div i_cluster_div (
    .ref_clk_i, .rst_i, .test_mode_i,
    .clk_o(cluster_clk_o),
    .ctrl(cluster_ctrl.div)
  );

  // each port reports the lock of its own domain
  assign soc_cfg_lock_o     = soc_ctrl.locked;
  assign per_cfg_lock_o     = per_ctrl.locked;
  assign cluster_cfg_lock_o = cluster_ctrl.locked;

endmodule : clk_gen

// ==== clk_gen_checker.sv ====
// ----------------------------------------
// handshake and lock assertions
// bound into every register block and divider
// ----------------------------------------

`timescale 1ns/1ps

module clk_gen_checker #(
  parameter bit CHECK_CFG  = 1'b1,
  parameter bit CHECK_LOCK = 1'b1
) (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic ack_i,
  input logic reload_i,
  input logic locked_i
);

  // number of failed assertions in this instance
  int fails = 0;

  // an ack only ever answers a req seen in the cycle before
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i || !CHECK_CFG)
    $rose(ack_i) |-> $past(req_i)) else begin
    fails++;
    $error("ack rose without a pending req");
  end

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i || !CHECK_CFG)
    ack_i |=> !ack_i) else begin
    fails++;
    $error("ack held for more than one cycle");
  end

  // the settle time starts over, so lock has to be gone right after reload
  lock_drops: assert property (@(posedge clk_i) disable iff (rst_i || !CHECK_LOCK)
    reload_i |=> !locked_i) else begin
    fails++;
    $error("lock still high in the cycle after reload");
  end

endmodule : clk_gen_checker

bind clk_cfg_regs clk_gen_checker #(.CHECK_CFG(1'b1), .CHECK_LOCK(1'b0)) i_cfg_chk (
  .clk_i(ref_clk_i), .rst_i(rst_i), .req_i(cfg_req_i), .ack_i(cfg_ack_o),
  .reload_i(1'b0), .locked_i(1'b0)
);

bind clk_div clk_gen_checker #(.CHECK_CFG(1'b0), .CHECK_LOCK(1'b1)) i_div_chk (
  .clk_i(ref_clk_i), .rst_i(rst_i), .req_i(1'b0), .ack_i(1'b0),
  .reload_i(ctrl.reload), .locked_i(ctrl.locked)
);

// ==== tb_clk_gen.sv ====
// ----------------------------------------
// testbench of the clock generation subsystem
// drives the three configuration ports, checks every read against
// a shadow model and times the divided clocks and lock
// ----------------------------------------

`timescale 1ns/1ps
`include "clk_gen_cfg.svh"

module tb_clk_gen;

  import clk_cfg_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int ACK_TIMEOUT    = 8;
  localparam int PERIOD_TIMEOUT = 8 * 16;
  // the tests take at most about 750 reference cycles
  // the watchdog allows 1000
  localparam int RUN_CYCLES     = 1000;
  localparam int WATCHDOG_NS    = RUN_CYCLES * CLK_PERIOD;

  logic       ref_clk = 1'b0;
  logic       rst;
  logic       test_mode;
  // index 0 is soc, 1 is per, 2 is cluster
  logic [2:0] req;
  logic [2:0] wrn;
  cfg_addr_t  add [3];
  cfg_data_t  wdata [3];
  wire  [2:0] ack;
  wire  [2:0] lock;
  wire  [2:0] clk_out;
  wire  [`CLK_CFG_DATA_W-1:0] rdata [3];

  // shadow of the writable registers of each domain
  logic [`CLK_DIV_W-1:0] sh_div [3];
  logic                  sh_en [3];

  // reads waiting for the compare process
  cfg_data_t got_q [$];
  cfg_data_t exp_q [$];
  string     tag_q [$];
  cfg_data_t cmp_got;
  cfg_data_t cmp_exp;
  string     cmp_tag;

  int cyc     = 0;
  int errors  = 0;
  int checks  = 0;
  int seed    = 97;
  int rel_cyc = 0;

  clk_gen DUT (
    .ref_clk_i(ref_clk), .rst_i(rst), .test_mode_i(test_mode),
    .soc_clk_o(clk_out[0]), .per_clk_o(clk_out[1]), .cluster_clk_o(clk_out[2]),
    .soc_cfg_req_i(req[0]), .soc_cfg_wrn_i(wrn[0]),
    .soc_cfg_add_i(add[0]), .soc_cfg_data_i(wdata[0]),
    .soc_cfg_ack_o(ack[0]), .soc_cfg_r_data_o(rdata[0]), .soc_cfg_lock_o(lock[0]),
    .per_cfg_req_i(req[1]), .per_cfg_wrn_i(wrn[1]),
    .per_cfg_add_i(add[1]), .per_cfg_data_i(wdata[1]),
    .per_cfg_ack_o(ack[1]), .per_cfg_r_data_o(rdata[1]), .per_cfg_lock_o(lock[1]),
    .cluster_cfg_req_i(req[2]), .cluster_cfg_wrn_i(wrn[2]),
    .cluster_cfg_add_i(add[2]), .cluster_cfg_data_i(wdata[2]),
    .cluster_cfg_ack_o(ack[2]), .cluster_cfg_r_data_o(rdata[2]),
    .cluster_cfg_lock_o(lock[2])
  );

  always #(CLK_PERIOD / 2) ref_clk = ~ref_clk;

  // counts rising edges of ref_clk, read only at falling edges
  always @(posedge ref_clk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------
  // reference model and helpers
  // ----------------------------------------
  // expected read data of domain d from the register map and the shadow
  function automatic cfg_data_t expected_read(input int d, input cfg_addr_t a,
                                              input logic lock_exp);
    cfg_data_t r;
    case (a)
      REG_DIV:    r = cfg_data_t'(sh_div[d]);
      REG_EN:     r = cfg_data_t'(sh_en[d]);
      REG_STATUS: r = cfg_data_t'(lock_exp);
      REG_ID:     r = {16'(d + 1), `CLK_ID_VERSION};
      default:    r = '0;
    endcase
    return r;
  endfunction

  task automatic check_equal(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // waits for the ack of domain d and samples read data and cycle in the ack cycle
  // req stays up through the ack cycle and drops in the cycle after it
  task automatic wait_ack(input int d, output logic seen, output cfg_data_t rd,
                          output int ack_cyc);
    int n;
    n = 0;
    @(negedge ref_clk);
    while (!ack[d] && n < ACK_TIMEOUT) begin
      @(negedge ref_clk);
      n++;
    end
    seen    = ack[d];
    rd      = rdata[d];
    ack_cyc = cyc;
    if (!seen) begin
      errors++;
      $display("domain %0d gave no ack within %0d cycles", d, ACK_TIMEOUT);
    end else begin
      // ack comes in the cycle right after req is first seen
      check_equal($sformatf("domain %0d cycles from req to ack", d), n, 0);
    end
    @(negedge ref_clk);
    req[d] = 1'b0;
  endtask

  task automatic cfg_write(input int d, input cfg_addr_t a, input cfg_data_t data,
                           output int ack_cyc);
    logic      seen;
    cfg_data_t rd;
    @(negedge ref_clk);
    req[d]   = 1'b1;
    wrn[d]   = 1'b0;
    add[d]   = a;
    wdata[d] = data;
    wait_ack(d, seen, rd, ack_cyc);
    // read-only and unmapped addresses leave the shadow alone
    if (a == REG_DIV) begin
      sh_div[d] = data[`CLK_DIV_W-1:0];
    end
    if (a == REG_EN) begin
      sh_en[d] = data[0];
    end
  endtask

  task automatic cfg_read(input int d, input cfg_addr_t a, input logic lock_exp);
    logic      seen;
    cfg_data_t rd;
    int        ack_cyc;
    @(negedge ref_clk);
    req[d]   = 1'b1;
    wrn[d]   = 1'b1;
    add[d]   = a;
    wdata[d] = '0;
    wait_ack(d, seen, rd, ack_cyc);
    if (seen) begin
      got_q.push_back(rd);
      exp_q.push_back(expected_read(d, a, lock_exp));
      tag_q.push_back($sformatf("domain %0d address %0d", d, a));
    end
  endtask

  // lock must rise exactly CLK_LOCK_CYCLES edges after start_cyc
  task automatic wait_lock(input int d, input int start_cyc);
    int n;
    n = 0;
    while (!lock[d] && n < 4 * `CLK_LOCK_CYCLES) begin
      @(negedge ref_clk);
      n++;
    end
    if (!lock[d]) begin
      errors++;
      $display("lock of domain %0d never rose", d);
    end else begin
      check_equal($sformatf("domain %0d cycles to lock", d), cyc - start_cyc,
                  `CLK_LOCK_CYCLES);
    end
  endtask

  // counts reference edges between two rising edges of the domain clock
  task automatic check_period(input int d, input int exp);
    logic prev;
    logic rise;
    int   n;
    int   w;
    prev = clk_out[d];
    rise = 1'b0;
    n    = 0;
    w    = 0;
    while (!rise && w < PERIOD_TIMEOUT) begin
      @(negedge ref_clk);
      w++;
      rise = clk_out[d] && !prev;
      prev = clk_out[d];
    end
    rise = 1'b0;
    while (!rise && w < PERIOD_TIMEOUT) begin
      @(negedge ref_clk);
      w++;
      n++;
      rise = clk_out[d] && !prev;
      prev = clk_out[d];
    end
    if (!rise) begin
      errors++;
      $display("no full period seen on the clock of domain %0d", d);
    end else begin
      check_equal($sformatf("domain %0d period in reference cycles", d), n, exp);
    end
  endtask

  // compare process for every queued read
  always @(posedge ref_clk) begin
    while (got_q.size() > 0) begin
      cmp_got = got_q.pop_front();
      cmp_exp = exp_q.pop_front();
      cmp_tag = tag_q.pop_front();
      checks++;
      assert (cmp_got == cmp_exp) else begin
        errors++;
        $display("ERROR at time %0t: %s read 0x%08h, expected 0x%08h",
                 $time, cmp_tag, cmp_got, cmp_exp);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    int ac;
    int val;
    int n;
    int asrt_fails;
    rst       = 1'b1;
    test_mode = 1'b0;
    req       = '0;
    wrn       = '1;
    for (int d = 0; d < 3; d++) begin
      add[d]    = '0;
      wdata[d]  = '0;
      sh_div[d] = `CLK_DIV_RESET;
      sh_en[d]  = 1'b1;
    end
    repeat (10) @(posedge ref_clk);
    @(negedge ref_clk);
    rst     = 1'b0;
    rel_cyc = cyc;

    // all three domains lock together after reset
    n = 0;
    while (lock == 3'b000 && n < 4 * `CLK_LOCK_CYCLES) begin
      @(negedge ref_clk);
      n++;
    end
    check_equal("lock vector after reset", lock, 3'b111);
    check_equal("cycles from reset release to lock", cyc - rel_cyc, `CLK_LOCK_CYCLES);

    // reset values, id word and unmapped addresses
    for (int d = 0; d < 3; d++) begin
      cfg_read(d, REG_DIV, 1'b1);
      cfg_read(d, REG_EN, 1'b1);
      cfg_read(d, REG_STATUS, 1'b1);
      cfg_read(d, REG_ID, 1'b1);
      cfg_read(d, 5'd4, 1'b1);
      cfg_read(d, 5'd31, 1'b1);
    end

    // random writes stay in their own domain, read-only writes are dropped
    for (int d = 0; d < 3; d++) begin
      cfg_write(d, REG_DIV, $random(seed), ac);
      cfg_write(d, REG_EN, $random(seed) & 1, ac);
      for (int e = 0; e < 3; e++) begin
        cfg_read(e, REG_DIV, 1'b0);
        cfg_read(e, REG_EN, 1'b0);
      end
      cfg_write(d, REG_ID, $random(seed), ac);
      cfg_write(d, REG_STATUS, $random(seed), ac);
      cfg_read(d, REG_ID, 1'b0);
      cfg_read(d, REG_DIV, 1'b0);
    end

    // output period is twice the divider, a zero divides like a one
    for (int r = 0; r < 2; r++) begin
      for (int d = 0; d < 3; d++) begin
        val = $random(seed) & 15;
        if (r == 0 && d == 0) begin
          val = 0;
        end
        cfg_write(d, REG_EN, 1, ac);
        cfg_write(d, REG_DIV, val, ac);
        check_period(d, 2 * ((val == 0) ? 1 : val));
      end
    end

    // a divider write drops lock and restarts the settle time
    for (int d = 0; d < 3; d++) begin
      // the write returns in the cycle after its ack
      cfg_write(d, REG_DIV, $random(seed), ac);
      check_equal($sformatf("domain %0d lock after reload", d), lock[d], 0);
      cfg_read(d, REG_STATUS, 1'b0);
      wait_lock(d, ac);
      cfg_read(d, REG_STATUS, 1'b1);
    end

    // disabled domains hold the clock and lock low
    for (int d = 0; d < 3; d++) begin
      // a divider of one would toggle the clock every cycle
      cfg_write(d, REG_DIV, 1, ac);
      cfg_write(d, REG_EN, 0, ac);
      // watching past the settle time catches a lock that comes back
      repeat (2 * `CLK_LOCK_CYCLES) begin
        check_equal($sformatf("domain %0d clock while disabled", d), clk_out[d], 0);
        check_equal($sformatf("domain %0d lock while disabled", d), lock[d], 0);
        @(negedge ref_clk);
      end
      cfg_read(d, REG_STATUS, 1'b0);
      cfg_read(d, REG_EN, 1'b0);
      cfg_write(d, REG_EN, 1, ac);
      wait_lock(d, ac);
    end

    // test mode passes ref_clk through, lock stays as it was
    @(negedge ref_clk);
    test_mode = 1'b1;
    repeat (8) begin
      @(posedge ref_clk);
      #1;
      check_equal("clocks in test mode, high phase", clk_out, 3'b111);
      @(negedge ref_clk);
      #1;
      check_equal("clocks in test mode, low phase", clk_out, 3'b000);
      check_equal("lock in test mode", lock, 3'b111);
    end
    @(negedge ref_clk);
    test_mode = 1'b0;

    repeat (2) @(negedge ref_clk);
    asrt_fails = DUT.i_soc_regs.i_cfg_chk.fails + DUT.i_per_regs.i_cfg_chk.fails +
                 DUT.i_cluster_regs.i_cfg_chk.fails + DUT.i_soc_div.i_div_chk.fails +
                 DUT.i_per_div.i_div_chk.fails + DUT.i_cluster_div.i_div_chk.fails;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_clk_gen

// ==== project.f ====
+incdir+.
clk_cfg_pkg.sv
clk_div_pkg.sv
clk_ctrl_if.sv
clk_cfg_regs.sv
clk_div.sv
clk_gen.sv
clk_gen_checker.sv
tb_clk_gen.sv

// ==== Bender.yml ====
package:
  name: clk_gen

sources:
  - include_dirs:
      - .
    files:
      - clk_cfg_pkg.sv
      - clk_div_pkg.sv
      - clk_ctrl_if.sv
      - clk_cfg_regs.sv
      - clk_div.sv
      - clk_gen.sv

  - target: test
    include_dirs:
      - .
    files:
      - clk_gen_checker.sv
      - tb_clk_gen.sv
